// ==== common/ossc_macros.svh ====
// Register map, field positions, OSD palette and counter widths for the output side
`ifndef OSSC_MACROS_SVH
`define OSSC_MACROS_SVH

// Register word addresses
`define OSSC_REG_CTRL   4'h0
`define OSSC_REG_STATUS 4'h1

// Control register fields
`define OSSC_CTRL_POWERON_BIT   0
`define OSSC_CTRL_FRAMELOCK_BIT 1
`define OSSC_CTRL_FAN_LSB       4
`define OSSC_CTRL_LED_LSB       8

// Status register fields
`define OSSC_STATUS_BTN_LSB 0

// OSD palette, black / blue / yellow / white
`define OSSC_OSD_COLOR0 24'h000000
`define OSSC_OSD_COLOR1 24'h0000ff
`define OSSC_OSD_COLOR2 24'hffff00
`define OSSC_OSD_COLOR3 24'hffffff

`define OSSC_PWM_CNT_BITS    6
`define OSSC_RESYNC_LED_BITS 8

`endif

// ==== common/ossc_pkg.sv ====
// Shared types for the scan converter output side: register map, video, OSD and Wishbone
`default_nettype none

package ossc_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // One pixel with its timing bits
    typedef struct packed {
        rgb_t pixel;
        logic hsync;
        logic vsync;
        logic de;
    } video_t;

    typedef struct packed {
        logic       enable;
        logic [1:0] color;
    } osd_t;

    // Front-panel buttons, low when pressed
    typedef logic [5:0] btn_t;

    // Decoded control register
    typedef struct packed {
        logic       poweron;
        logic       framelock;
        logic [3:0] fan_duty;
        logic [3:0] led_duty;
    } sys_ctrl_t;

    // Wishbone classic, word addressed
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/cdc_sync.sv ====
// Two-flop synchronizer for asynchronous board inputs of any payload type
`default_nettype none

module cdc_sync #(
    parameter type      payload_t   = logic,
    parameter payload_t RESET_VALUE = '0
) (
    input  logic     pclk_out,
    input  logic     po_reset_n,
    input  payload_t async_i,
    output payload_t sync_o
);

    payload_t meta_q;
    payload_t sync_q;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            meta_q <= RESET_VALUE;
            sync_q <= RESET_VALUE;
        end else begin
            meta_q <= async_i;
            sync_q <= meta_q;
        end
    end

    assign sync_o = sync_q;

endmodule

`default_nettype wire

// ==== hdl/indicator_drive.sv ====
// LED and fan drive with resync hold timer, status LED mask and fan polarity
`default_nettype none
`include "ossc_macros.svh"

module indicator_drive (
    input  logic            pclk_out,
    input  logic            po_reset_n,
    input  logic            poweron_i,
    input  logic            framelock_i,
    input  ossc_pkg::btn_t  btn_i,
    input  logic            resync_i,
    input  logic            fan_pwm_i,
    input  logic            led_pwm_i,
    output logic [2:0]      led_o,
    output logic            fan_pwm_o
);
    import ossc_pkg::*;

    localparam btn_t BTN_RELEASED = '1;

    logic                             resync_prev_q;
    logic                             resync_rise;
    logic [`OSSC_RESYNC_LED_BITS-1:0] hold_q;
    logic                             btn_pressed;
    logic [2:0]                       led_mask;

    assign resync_rise = resync_i & ~resync_prev_q;
    assign btn_pressed = (btn_i != BTN_RELEASED);

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_prev_q <= 1'b0;
            hold_q        <= '0;
        end else begin
            resync_prev_q <= resync_i;
            if (!poweron_i) begin
                hold_q <= '0;
            end else if (resync_rise) begin
                hold_q <= '1;
            end else if (hold_q != '0) begin
                hold_q <= hold_q - 1'b1;
            end
        end
    end

    // Blue: framelock, green: button, red: recent resync
    assign led_mask = poweron_i ? {framelock_i, btn_pressed, (hold_q != '0)} : 3'b000;
    assign led_o    = {3{led_pwm_i}} & led_mask;

    // Fan input is active low
    assign fan_pwm_o = ~(poweron_i & fan_pwm_i);

endmodule

`default_nettype wire

// ==== hdl/ossc_out_top.sv ====
// Output side top level of the scan converter, control block plus video, PWM and indicators
`default_nettype none

module ossc_out_top (
    input  logic                pclk_out,
    input  logic                po_reset_n,
    input  ossc_pkg::wb_req_t   wb_req_i,
    output ossc_pkg::wb_rsp_t   wb_rsp_o,
    input  ossc_pkg::video_t    video_i,
    input  ossc_pkg::osd_t      osd_i,
    input  ossc_pkg::btn_t      btn_i,
    input  logic                resync_strobe_i,
    output ossc_pkg::video_t    video_o,
    output logic [2:0]          led_o,
    output logic                fan_pwm_o,
    output logic                hdmitx_5v_en_o
);
    import ossc_pkg::*;

    sys_ctrl_t sys_ctrl;
    btn_t      btn_sync;
    logic      resync_sync;
    logic      fan_pwm;
    logic      led_pwm;

    assign hdmitx_5v_en_o = sys_ctrl.poweron;

    sys_ctrl_regs u_sys_ctrl_regs (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .btn_i      (btn_sync),
        .ctrl_o     (sys_ctrl)
    );

    // Buttons idle high
    cdc_sync #(
        .payload_t   (btn_t),
        .RESET_VALUE ('1)
    ) sync_btn (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .async_i    (btn_i),
        .sync_o     (btn_sync)
    );

    cdc_sync #(
        .payload_t   (logic),
        .RESET_VALUE (1'b0)
    ) sync_resync (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .async_i    (resync_strobe_i),
        .sync_o     (resync_sync)
    );

    pwm_2ch u_pwm (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .ch1_duty_i (sys_ctrl.fan_duty),
        .ch2_duty_i (sys_ctrl.led_duty),
        .ch1_pwm_o  (fan_pwm),
        .ch2_pwm_o  (led_pwm)
    );

    indicator_drive u_indicator (
        .pclk_out    (pclk_out),
        .po_reset_n  (po_reset_n),
        .poweron_i   (sys_ctrl.poweron),
        .framelock_i (sys_ctrl.framelock),
        .btn_i       (btn_sync),
        .resync_i    (resync_sync),
        .fan_pwm_i   (fan_pwm),
        .led_pwm_i   (led_pwm),
        .led_o       (led_o),
        .fan_pwm_o   (fan_pwm_o)
    );

    video_out_pipe u_video_out (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n),
        .video_i    (video_i),
        .osd_i      (osd_i),
        .video_o    (video_o)
    );

endmodule

`default_nettype wire

// ==== hdl/pwm_2ch.sv ====
// Two-channel PWM sharing one free-running period counter
`default_nettype none
`include "ossc_macros.svh"

module pwm_2ch (
    input  logic       pclk_out,
    input  logic       po_reset_n,
    input  logic [3:0] ch1_duty_i,
    input  logic [3:0] ch2_duty_i,
    output logic       ch1_pwm_o,
    output logic       ch2_pwm_o
);

    logic [`OSSC_PWM_CNT_BITS-1:0] cnt_q;
    logic [3:0]                    cnt_hi;
    logic                          ch1_q;
    logic                          ch2_q;

    // Duty steps of 4 cycles each
    assign cnt_hi = cnt_q[`OSSC_PWM_CNT_BITS-1 -: 4];

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ch1_q <= 1'b0;
            ch2_q <= 1'b0;
        end else begin
            ch1_q <= (cnt_hi < ch1_duty_i);
            ch2_q <= (cnt_hi < ch2_duty_i);
        end
    end

    assign ch1_pwm_o = ch1_q;
    assign ch2_pwm_o = ch2_q;

endmodule

`default_nettype wire

// ==== hdl/sys_ctrl_regs.sv ====
// Wishbone classic slave with the control register and the button status register
`default_nettype none
`include "ossc_macros.svh"

module sys_ctrl_regs (
    input  logic                 pclk_out,
    input  logic                 po_reset_n,
    input  ossc_pkg::wb_req_t    wb_req_i,
    output ossc_pkg::wb_rsp_t    wb_rsp_o,
    input  ossc_pkg::btn_t       btn_i,
    output ossc_pkg::sys_ctrl_t  ctrl_o
);
    import ossc_pkg::*;

    logic        ack_q;
    logic [31:0] rd_dat;
    logic [31:0] rd_dat_q;
    sys_ctrl_t   ctrl_q;
    logic        req_new;
    logic        sel_ctrl;
    logic        sel_status;

    // New request only while no ack is pending
    assign req_new    = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign sel_ctrl   = (wb_req_i.adr == `OSSC_REG_CTRL);
    assign sel_status = (wb_req_i.adr == `OSSC_REG_STATUS);

    always_comb begin
        rd_dat = '0;
        if (sel_ctrl) begin
            rd_dat[`OSSC_CTRL_POWERON_BIT]   = ctrl_q.poweron;
            rd_dat[`OSSC_CTRL_FRAMELOCK_BIT] = ctrl_q.framelock;
            rd_dat[`OSSC_CTRL_FAN_LSB +: 4]  = ctrl_q.fan_duty;
            rd_dat[`OSSC_CTRL_LED_LSB +: 4]  = ctrl_q.led_duty;
        end else if (sel_status) begin
            rd_dat[`OSSC_STATUS_BTN_LSB +: $bits(btn_t)] = btn_i;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            ack_q  <= 1'b0;
            ctrl_q <= '0;
        end else begin
            ack_q <= req_new;
            // Write lands on the same edge that raises ack
            if (req_new && wb_req_i.we && sel_ctrl) begin
                ctrl_q.poweron   <= wb_req_i.dat[`OSSC_CTRL_POWERON_BIT];
                ctrl_q.framelock <= wb_req_i.dat[`OSSC_CTRL_FRAMELOCK_BIT];
                ctrl_q.fan_duty  <= wb_req_i.dat[`OSSC_CTRL_FAN_LSB +: 4];
                ctrl_q.led_duty  <= wb_req_i.dat[`OSSC_CTRL_LED_LSB +: 4];
            end
        end
    end

    always_ff @(posedge pclk_out) begin
        if (req_new) begin
            rd_dat_q <= rd_dat;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_dat_q;
    assign ctrl_o       = ctrl_q;

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+common
common/ossc_pkg.sv
hdl/cdc_sync.sv
hdl/pwm_2ch.sv
hdl/indicator_drive.sv
hdl/sys_ctrl_regs.sv
video_out/video_out_pipe.sv
hdl/ossc_out_top.sv
verification/ossc_out_checker.sv
verification/tb_clk_gen.sv
verification/ossc_out_tb.sv

// ==== verification/ossc_out_checker.sv ====
// Bound Wishbone ack and fan polarity assertions for the output side top level
`default_nettype none

module ossc_out_checker (
    input logic pclk_out,
    input logic po_reset_n,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic poweron_i,
    input logic fan_pwm_i
);

    // Failed assertion count
    int unsigned failures = 0;

    ack_single_cycle: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        wb_ack_i |=> !wb_ack_i
    ) else begin
        $error("Wishbone ack stayed high for two cycles");
        failures++;
    end

    ack_after_request: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        wb_ack_i |-> $past(wb_cyc_i && wb_stb_i)
    ) else begin
        $error("Wishbone ack without a request in the previous cycle");
        failures++;
    end

    // Fan input is active low, so no power means fan off
    fan_off_without_power: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        !poweron_i |-> fan_pwm_i
    ) else begin
        $error("Fan PWM driven low while poweron is clear");
        failures++;
    end

endmodule

bind ossc_out_top ossc_out_checker chk0 (
    .pclk_out   (pclk_out),
    .po_reset_n (po_reset_n),
    .wb_cyc_i   (wb_req_i.cyc),
    .wb_stb_i   (wb_req_i.stb),
    .wb_ack_i   (wb_rsp_o.ack),
    .poweron_i  (sys_ctrl.poweron),
    .fan_pwm_i  (fan_pwm_o)
);

`default_nettype wire

// ==== verification/ossc_out_tb.sv ====
// Directed testbench for the scan converter output side
`default_nettype none
`include "ossc_macros.svh"

module ossc_out_tb;
    import ossc_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int ACK_LIMIT  = 8;
    // Cycles for reset, registers, video, OSD, fan and indicators, then margin
    localparam int BUDGET_CYCLES = 20 + 60 + 40 + 30 + 520 + 820 + 200;

    logic        pclk_out;
    logic        po_reset_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    video_t      video_in;
    video_t      video_out;
    osd_t        osd;
    btn_t        btn;
    logic        resync_strobe;
    logic [2:0]  led;
    logic        fan_pwm;
    logic        hdmitx_5v_en;
    int          value_errors = 0;
    int          bus_errors = 0;

    tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) clk0 (
        .pclk_out   (pclk_out),
        .po_reset_n (po_reset_n)
    );

    ossc_out_top dut0 (
        .pclk_out        (pclk_out),
        .po_reset_n      (po_reset_n),
        .wb_req_i        (wb_req),
        .wb_rsp_o        (wb_rsp),
        .video_i         (video_in),
        .osd_i           (osd),
        .btn_i           (btn),
        .resync_strobe_i (resync_strobe),
        .video_o         (video_out),
        .led_o           (led),
        .fan_pwm_o       (fan_pwm),
        .hdmitx_5v_en_o  (hdmitx_5v_en)
    );

    task automatic compare_value(input string test_name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic bus_transfer(input logic [3:0] adr, input logic is_write,
                                input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: is_write, adr: adr, dat: wdat};
        do begin
            @(negedge pclk_out);
            waited++;
        end while (!wb_rsp.ack && waited < ACK_LIMIT);
        rdat = wb_rsp.dat;
        if (!wb_rsp.ack) begin
            $display("No Wishbone ack within %0d cycles for address %0d", ACK_LIMIT, adr);
            bus_errors++;
        end
        wb_req = '0;
        @(negedge pclk_out);
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_transfer(adr, 1'b1, wdat, unused);
    endtask

    task automatic read_reg(input logic [3:0] adr, output logic [31:0] rdat);
        bus_transfer(adr, 1'b0, '0, rdat);
    endtask

    // Control register layout with led_duty at 11:8, fan_duty at 7:4, framelock at 1
    // and poweron at 0
    function automatic logic [31:0] ctrl_word(input logic po, input logic fl,
                                              input logic [3:0] fan, input logic [3:0] led_duty);
        ctrl_word = {20'b0, led_duty, fan, 2'b00, fl, po};
    endfunction

    function automatic rgb_t palette_color(input logic [1:0] idx);
        case (idx)
            2'd0:    palette_color = `OSSC_OSD_COLOR0;
            2'd1:    palette_color = `OSSC_OSD_COLOR1;
            2'd2:    palette_color = `OSSC_OSD_COLOR2;
            default: palette_color = `OSSC_OSD_COLOR3;
        endcase
    endfunction

    task automatic observe(input int cycles, output int fan_low, output int led2,
                           output int led1, output int led0);
        fan_low = 0;
        led2 = 0;
        led1 = 0;
        led0 = 0;
        repeat (cycles) begin
            @(negedge pclk_out);
            fan_low += !fan_pwm;
            led2 += led[2];
            led1 += led[1];
            led0 += led[0];
        end
    endtask

    task automatic check_reset_values();
        logic [31:0] rd;
        compare_value("reset_ack", 0, wb_rsp.ack);
        compare_value("reset_video", 0, video_out);
        compare_value("reset_led", 0, led);
        compare_value("reset_fan", 1, fan_pwm);
        compare_value("reset_hdmitx_5v", 0, hdmitx_5v_en);
        read_reg(`OSSC_REG_CTRL, rd);
        compare_value("reset_ctrl", 0, rd);
    endtask

    task automatic exercise_registers();
        logic [31:0] wdat;
        logic [31:0] rd;
        logic [31:0] rnd;
        logic [3:0]  adr;
        wdat = $urandom;
        write_reg(`OSSC_REG_CTRL, wdat);
        read_reg(`OSSC_REG_CTRL, rd);
        compare_value("ctrl_readback", wdat & 32'h0000_0ff3, rd);
        adr = 4'(2 + $urandom_range(13));
        write_reg(adr, $urandom);
        read_reg(adr, rd);
        compare_value("unmapped_read", 0, rd);
        read_reg(`OSSC_REG_CTRL, rd);
        compare_value("ctrl_after_unmapped_write", wdat & 32'h0000_0ff3, rd);
        rnd = $urandom;
        btn = rnd[5:0];
        repeat (3) @(negedge pclk_out);
        read_reg(`OSSC_REG_STATUS, rd);
        compare_value("button_status", {26'b0, btn}, rd);
        btn = '1;
    endtask

    // Each pixel is due at video_out two falling edges after it was driven
    task automatic stream_video(input string test_name, input logic osd_on, input int count);
        video_t      sent[$];
        video_t      pix;
        logic [31:0] rnd;
        for (int i = 0; i < count + 2; i++) begin
            if (i >= 2) begin
                compare_value($sformatf("%s[%0d]", test_name, i - 2), sent.pop_front(),
                              video_out);
            end
            if (i < count) begin
                rnd = $urandom;
                pix = rnd[26:0];
                video_in = pix;
                osd = '{enable: osd_on, color: i[1:0]};
                if (osd_on) begin
                    pix.pixel = palette_color(i[1:0]);
                end
                sent.push_back(pix);
            end else begin
                video_in = '0;
                osd = '0;
            end
            @(negedge pclk_out);
        end
    endtask

    task automatic measure_fan_pwm();
        int         fan_low;
        int         l2;
        int         l1;
        int         l0;
        logic [3:0] duties[4] = '{4'd0, 4'd3, 4'd9, 4'd15};
        foreach (duties[k]) begin
            write_reg(`OSSC_REG_CTRL, ctrl_word(1'b1, 1'b0, duties[k], 4'd0));
            repeat (2) @(negedge pclk_out);
            observe(64, fan_low, l2, l1, l0);
            compare_value($sformatf("fan_low_duty%0d", duties[k]), 4 * duties[k], fan_low);
            compare_value("hdmitx_5v_on", 1, hdmitx_5v_en);
        end
        write_reg(`OSSC_REG_CTRL, ctrl_word(1'b0, 1'b0, 4'd15, 4'd0));
        observe(128, fan_low, l2, l1, l0);
        compare_value("fan_power_off", 0, fan_low);
        compare_value("hdmitx_5v_off", 0, hdmitx_5v_en);
    endtask

    task automatic exercise_indicators();
        int   fan_low;
        int   l2;
        int   l1;
        int   l0;
        int   resync_hits;
        btn_t pressed;
        write_reg(`OSSC_REG_CTRL, ctrl_word(1'b1, 1'b1, 4'd0, 4'd15));
        observe(64, fan_low, l2, l1, l0);
        compare_value("led_framelock", 60, l2);
        compare_value("led_no_button", 0, l1);
        compare_value("led_no_resync", 0, l0);
        write_reg(`OSSC_REG_CTRL, ctrl_word(1'b1, 1'b0, 4'd0, 4'd15));
        observe(64, fan_low, l2, l1, l0);
        compare_value("led_no_framelock", 0, l2);
        pressed = '1;
        pressed[$urandom_range(5)] = 1'b0;
        btn = pressed;
        repeat (3) @(negedge pclk_out);
        observe(64, fan_low, l2, l1, l0);
        compare_value("led_button", 60, l1);
        btn = '1;
        repeat (3) @(negedge pclk_out);
        observe(64, fan_low, l2, l1, l0);
        compare_value("led_button_released", 0, l1);
        // Strobe held for 3 cycles from its start
        resync_hits = 0;
        resync_strobe = 1'b1;
        for (int i = 0; i < 70; i++) begin
            @(negedge pclk_out);
            if (i == 2) begin
                resync_strobe = 1'b0;
            end
            resync_hits += led[0];
        end
        compare_value("resync_led_on", 1, resync_hits != 0);
        repeat (230) @(negedge pclk_out);
        observe(128, fan_low, l2, l1, l0);
        compare_value("resync_led_expired", 0, l0);
        write_reg(`OSSC_REG_CTRL, ctrl_word(1'b0, 1'b1, 4'd0, 4'd15));
        btn = pressed;
        resync_strobe = 1'b1;
        repeat (3) @(negedge pclk_out);
        resync_strobe = 1'b0;
        observe(64, fan_low, l2, l1, l0);
        compare_value("led_power_off", 0, l2 + l1 + l0);
        btn = '1;
    endtask

    initial begin
        void'($urandom(82));
        wb_req = '0;
        // Busy video input while in reset
        video_in = '1;
        osd = '0;
        btn = '1;
        resync_strobe = 1'b0;
        wait (po_reset_n === 1'b1);
        @(negedge pclk_out);
        check_reset_values();
        exercise_registers();
        stream_video("video_pass", 1'b0, 24);
        stream_video("osd_overlay", 1'b1, 12);
        measure_fan_pwm();
        exercise_indicators();
        $display("Summary: %0d value mismatches, %0d bus timeouts, %0d assertion failures",
                 value_errors, bus_errors, dut0.chk0.failures);
        if (value_errors + bus_errors + dut0.chk0.failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(BUDGET_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", BUDGET_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
// Testbench clock and power-on reset source
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic pclk_out,
    output logic po_reset_n
);

    initial begin
        pclk_out = 1'b0;
        forever #(PERIOD / 2) pclk_out = ~pclk_out;
    end

    // Release away from the rising edge
    initial begin
        po_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge pclk_out);
        @(negedge pclk_out);
        po_reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== video_out/video_out_pipe.sv ====
// Video output pipeline, OSD palette overlay followed by the HDMI launch register
`default_nettype none
`include "ossc_macros.svh"

module video_out_pipe (
    input  logic              pclk_out,
    input  logic              po_reset_n,
    input  ossc_pkg::video_t  video_i,
    input  ossc_pkg::osd_t    osd_i,
    output ossc_pkg::video_t  video_o
);
    import ossc_pkg::*;

    rgb_t   osd_px;
    video_t overlay;
    video_t stage1_q;
    video_t stage2_q;

    always_comb begin
        case (osd_i.color)
            2'd0:    osd_px = `OSSC_OSD_COLOR0;
            2'd1:    osd_px = `OSSC_OSD_COLOR1;
            2'd2:    osd_px = `OSSC_OSD_COLOR2;
            default: osd_px = `OSSC_OSD_COLOR3;
        endcase
    end

    // Only the pixel is replaced, timing bits pass as-is
    always_comb begin
        overlay = video_i;
        if (osd_i.enable) begin
            overlay.pixel = osd_px;
        end
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            stage1_q <= '0;
        end else begin
            stage1_q <= overlay;
        end
    end

    // Launch register towards the HDMI transmitter
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            stage2_q <= '0;
        end else begin
            stage2_q <= stage1_q;
        end
    end

    assign video_o = stage2_q;

endmodule

`default_nettype wire
